//--- hw/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

  ////////////////////////////////////////
  // pixel and coordinate formats
  ////////////////////////////////////////
  localparam int gfx_x_bits     = 8;  // up to 256 columns
  localparam int gfx_y_bits     = 8;
  localparam int gfx_pixel_bits = 12; // 4 bits each of r, g, b

  typedef logic [gfx_pixel_bits-1:0] gfx_color_t; // red in the top nibble

  typedef enum logic [2-1:0] {
    pat_bars    = 2'd0,
    pat_checker = 2'd1,
    pat_solid   = 2'd2
  } gfx_pattern_e;

  typedef struct packed {
    logic [gfx_x_bits-1:0] x;
    logic [gfx_y_bits-1:0] y;
    gfx_color_t            color;
    logic                  last;  // final pixel of the frame
  } gfx_pixel_t;

  ////////////////////////////////////////
  // AXI4-Lite host port
  ////////////////////////////////////////
  localparam int axil_addr_w = 4;
  localparam int axil_data_w = 32;

  typedef struct packed {
    logic [axil_addr_w-1:0] addr;
  } axil_aw_t; // shared by aw and ar

  typedef struct packed {
    logic [axil_data_w-1:0] data;
  } axil_w_t;

  typedef struct packed {
    logic [axil_data_w-1:0] data;
    logic [1:0]             resp;
  } axil_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  localparam logic [axil_addr_w-1:0] reg_ctrl     = 4'h0;
  localparam logic [axil_addr_w-1:0] reg_status   = 4'h4;
  localparam logic [axil_addr_w-1:0] reg_pix_addr = 4'h8;
  localparam logic [axil_addr_w-1:0] reg_pix_data = 4'hc;

endpackage

`default_nettype wire

//--- hw/gfx_test_pattern.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_test_pattern #(
  parameter int FB_WIDTH  = 12,
  parameter int FB_HEIGHT = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  gfx_pkg::gfx_pattern_e pattern,
  input  gfx_pkg::gfx_color_t  solid_color,
  output gfx_pkg::gfx_pixel_t  pix,
  output logic                 pix_valid
);

  import gfx_pkg::*;

  localparam logic [gfx_x_bits-1:0] last_x = gfx_x_bits'(FB_WIDTH - 1);
  localparam logic [gfx_y_bits-1:0] last_y = gfx_y_bits'(FB_HEIGHT - 1);
  localparam logic [gfx_x_bits-1:0] bar_g  = gfx_x_bits'(FB_WIDTH / 3);       // green starts
  localparam logic [gfx_x_bits-1:0] bar_b  = gfx_x_bits'(2 * (FB_WIDTH / 3)); // blue starts

  localparam gfx_color_t color_red = 12'hf00;
  localparam gfx_color_t color_grn = 12'h0f0;
  localparam gfx_color_t color_blu = 12'h00f;

  logic                  run;
  logic                  advance;
  logic [gfx_x_bits-1:0] nxt_x;
  logic [gfx_y_bits-1:0] nxt_y;

  // colour of one coordinate for the selected pattern
  function automatic gfx_color_t pattern_color(input logic [gfx_x_bits-1:0] x,
                                               input logic y_lsb);
    gfx_color_t c;
    case (pattern)
      pat_checker: c = {gfx_pixel_bits{x[0] ^ y_lsb}};
      pat_solid:   c = solid_color;
      default: begin // bars, and the unused fourth code
        if (x < bar_g) begin
          c = color_red;
        end else if (x < bar_b) begin
          c = color_grn;
        end else begin
          c = color_blu;
        end
      end
    endcase
    return c;
  endfunction

  ////////////////////////////////////////
  // raster sweep
  ////////////////////////////////////////
  always_comb begin
    nxt_x = '0; // next pixel is the origin when idle
    nxt_y = '0;
    if (run) begin
      if (pix.x == last_x) begin
        nxt_y = pix.y + 1'b1;
      end else begin
        nxt_x = pix.x + 1'b1;
        nxt_y = pix.y;
      end
    end
  end

  assign advance = (start && !run) || (run && !pix.last);

  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else if (start && !run) begin
      run <= 1'b1;
    end else if (run && pix.last) begin
      run <= 1'b0; // final pixel went out this cycle
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      pix.x     <= nxt_x;
      pix.y     <= nxt_y;
      pix.color <= pattern_color(nxt_x, nxt_y[0]);
      pix.last  <= (nxt_x == last_x) && (nxt_y == last_y);
    end
  end

  assign pix_valid = run;

  a_pix_in_range: assert property (@(posedge clk) disable iff (reset)
    pix_valid |-> (int'(pix.x) < FB_WIDTH) && (int'(pix.y) < FB_HEIGHT))
    else $error("pixel coordinate outside the framebuffer");

endmodule

`default_nettype wire

//--- hw/gfx_fb_writer.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_fb_writer #(
  parameter int FB_WIDTH  = 12,
  parameter int FB_HEIGHT = 4
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  gfx_pkg::gfx_pixel_t                   pix,
  input  logic                                  pix_valid,
  output logic                                  wr_en,
  output logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0] wr_addr,
  output gfx_pkg::gfx_color_t                   wr_data,
  output logic                                  frame_done
);

  import gfx_pkg::*;

  localparam int fb_depth  = FB_WIDTH * FB_HEIGHT;
  localparam int fb_addr_w = $clog2(fb_depth);

  logic [fb_addr_w-1:0] lin_addr;

  // row-major linear address
  assign lin_addr = fb_addr_w'(32'(pix.y) * FB_WIDTH + 32'(pix.x));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en      <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      wr_en      <= pix_valid;
      frame_done <= pix_valid && pix.last; // lines up with the final write
    end
  end

  always_ff @(posedge clk) begin
    wr_addr <= lin_addr;
    wr_data <= pix.color;
  end

  a_wr_addr_range: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> (int'(wr_addr) < fb_depth))
    else $error("framebuffer write past the last pixel");

endmodule

`default_nettype wire

//--- hw/gfx_framebuffer.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_framebuffer #(
  parameter int FB_WIDTH  = 12,
  parameter int FB_HEIGHT = 4
) (
  input  logic                                                 clk,
  input  logic                                                 wr_en,
  input  logic [$clog2(FB_WIDTH*FB_HEIGHT)-1:0]                wr_addr,
  input  gfx_pkg::gfx_color_t                                  wr_data,
  input  logic [gfx_pkg::gfx_x_bits+gfx_pkg::gfx_y_bits-1:0]   rd_addr,
  output gfx_pkg::gfx_color_t                                  rd_data
);

  import gfx_pkg::*;

  localparam int fb_depth  = FB_WIDTH * FB_HEIGHT;
  localparam int fb_addr_w = $clog2(fb_depth);

  gfx_color_t mem [fb_depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // host reads take one cycle and return black past the frame
  always_ff @(posedge clk) begin
    if (32'(rd_addr) < fb_depth) begin
      rd_data <= mem[rd_addr[fb_addr_w-1:0]];
    end else begin
      rd_data <= '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/gfx_ctrl_axil.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_ctrl_axil #(
  parameter int FB_WIDTH = 12
) (
  input  logic                  clk,
  input  logic                  reset,
  input  gfx_pkg::axil_aw_t     aw,
  input  logic                  awvalid,
  output logic                  awready,
  input  gfx_pkg::axil_w_t      w,
  input  logic                  wvalid,
  output logic                  wready,
  output gfx_pkg::axil_b_t      b,
  output logic                  bvalid,
  input  logic                  bready,
  input  gfx_pkg::axil_aw_t     ar,
  input  logic                  arvalid,
  output logic                  arready,
  output gfx_pkg::axil_r_t      r,
  output logic                  rvalid,
  input  logic                  rready,
  input  logic                  frame_done,
  input  gfx_pkg::gfx_color_t   rd_data,
  output logic                  start,
  output gfx_pkg::gfx_pattern_e pattern,
  output gfx_pkg::gfx_color_t   solid_color,
  output logic [gfx_pkg::gfx_x_bits+gfx_pkg::gfx_y_bits-1:0] rd_addr
);

  import gfx_pkg::*;

  localparam int         rd_addr_w = gfx_x_bits + gfx_y_bits;
  localparam logic [1:0] resp_okay = 2'b00;

  typedef enum logic [1:0] {ws_idle, ws_accept, ws_resp} wr_state_e;
  typedef enum logic [1:0] {rs_idle, rs_wait, rs_resp} rd_state_e;

  wr_state_e              wr_state;
  rd_state_e              rd_state;
  logic                   aw_w_ready;
  logic                   wr_fire;
  logic                   rd_fire;
  logic                   start_req;
  logic                   busy;
  logic                   done;
  logic [15:1]            ctrl_bits;
  logic [gfx_x_bits-1:0]  pix_x;
  logic [gfx_y_bits-1:0]  pix_y;
  logic [axil_addr_w-1:0] rd_sel;
  logic [axil_data_w-1:0] rd_word;
  logic [axil_data_w-1:0] r_data;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////
  assign awready   = aw_w_ready; // address and data always taken together
  assign wready    = aw_w_ready;
  assign wr_fire   = aw_w_ready && awvalid && wvalid;
  assign start_req = wr_fire && (aw.addr == reg_ctrl) && w.data[0] && !busy;
  assign b         = '{resp: resp_okay};

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state   <= ws_idle;
      aw_w_ready <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      case (wr_state)
        ws_idle: if (awvalid && wvalid) begin
          aw_w_ready <= 1'b1;
          wr_state   <= ws_accept;
        end
        ws_accept: if (wr_fire) begin
          aw_w_ready <= 1'b0;
          bvalid     <= 1'b1;
          wr_state   <= ws_resp;
        end
        ws_resp: if (bready) begin
          bvalid   <= 1'b0;
          wr_state <= ws_idle;
        end
        default: wr_state <= ws_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_bits   <= '0;
      pix_x       <= '0;
      pix_y       <= '0;
      pattern     <= pat_bars;
      solid_color <= '0;
    end else begin
      if (wr_fire && aw.addr == reg_ctrl) begin
        ctrl_bits <= w.data[15:1];
      end
      if (wr_fire && aw.addr == reg_pix_addr) begin
        pix_y <= w.data[15:8];
        pix_x <= w.data[7:0];
      end
      if (start_req) begin // fill settings frozen until the next start
        pattern     <= gfx_pattern_e'(w.data[2:1]);
        solid_color <= w.data[15:4];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      start <= start_req;
      if (start_req) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (frame_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////
  assign rd_fire = arvalid && arready;
  assign rd_addr = rd_addr_w'(32'(pix_y) * FB_WIDTH + 32'(pix_x)); // follows pix_addr
  assign r       = '{data: r_data, resp: resp_okay};

  always_comb begin
    case (rd_sel)
      reg_ctrl:     rd_word = {16'h0, ctrl_bits, 1'b0};
      reg_status:   rd_word = {30'h0, done, busy};
      reg_pix_addr: rd_word = {16'h0, pix_y, pix_x};
      reg_pix_data: rd_word = {20'h0, rd_data};
      default:      rd_word = '0; // unmapped
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_state <= rs_idle;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      case (rd_state)
        rs_idle: if (rd_fire) begin
          arready  <= 1'b0;
          rd_state <= rs_wait;
        end else begin
          arready <= 1'b1;
        end
        rs_wait: begin // ram output settles this cycle
          rvalid   <= 1'b1;
          rd_state <= rs_resp;
        end
        rs_resp: if (rready) begin
          rvalid   <= 1'b0;
          arready  <= 1'b1;
          rd_state <= rs_idle;
        end
        default: rd_state <= rs_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rd_sel <= ar.addr;
    end
    if (rd_state == rs_wait) begin
      r_data <= rd_word;
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_r_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(r))
    else $error("read response changed before rready");

endmodule

`default_nettype wire

//--- hw/gfx_top.sv
`timescale 1ns/1ns
`default_nettype none

module gfx_top #(
  parameter int FB_WIDTH  = 12,
  parameter int FB_HEIGHT = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  gfx_pkg::axil_aw_t aw,
  input  logic              awvalid,
  output logic              awready,
  input  gfx_pkg::axil_w_t  w,
  input  logic              wvalid,
  output logic              wready,
  output gfx_pkg::axil_b_t  b,
  output logic              bvalid,
  input  logic              bready,
  input  gfx_pkg::axil_aw_t ar,
  input  logic              arvalid,
  output logic              arready,
  output gfx_pkg::axil_r_t  r,
  output logic              rvalid,
  input  logic              rready
);

  import gfx_pkg::*;

  localparam int fb_addr_w = $clog2(FB_WIDTH * FB_HEIGHT);

  logic                             start;
  gfx_pattern_e                     pattern;
  gfx_color_t                       solid_color;
  gfx_pixel_t                       pix;
  logic                             pix_valid;
  logic                             wr_en;
  logic [fb_addr_w-1:0]             wr_addr;
  gfx_color_t                       wr_data;
  logic                             frame_done;
  logic [gfx_x_bits+gfx_y_bits-1:0] rd_addr;
  gfx_color_t                       rd_data;

  gfx_ctrl_axil #(.FB_WIDTH(FB_WIDTH)) u_ctrl (
    .clk, .reset,
    .aw, .awvalid, .awready,
    .w, .wvalid, .wready,
    .b, .bvalid, .bready,
    .ar, .arvalid, .arready,
    .r, .rvalid, .rready,
    .frame_done, .rd_data,
    .start, .pattern, .solid_color, .rd_addr
  );

  // stage 1
  gfx_test_pattern #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_pattern (
    .clk, .reset, .start, .pattern, .solid_color, .pix, .pix_valid
  );

  // stage 2
  gfx_fb_writer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_writer (
    .clk, .reset, .pix, .pix_valid, .wr_en, .wr_addr, .wr_data, .frame_done
  );

  // stage 3
  gfx_framebuffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) u_fb (
    .clk, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data
  );

endmodule

`default_nettype wire

//--- verification/tb_gfx_tasks.svh
////////////////////////////////////////
// compare tasks
////////////////////////////////////////
task automatic check_color(input string name, input gfx_color_t got, input gfx_color_t exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    report_failure("pixel colour mismatch");
  end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    report_failure("AXI response mismatch");
  end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
    report_failure("register word mismatch");
  end
endtask

////////////////////////////////////////
// AXI4-Lite host side
////////////////////////////////////////
// called and returning 2 ns after a rising edge
task automatic write_reg(input logic [axil_addr_w-1:0] addr, input logic [31:0] data);
  int n;
  aw.addr = addr;
  w.data  = data;
  awvalid = 1'b1;
  wvalid  = 1'b1;
  n = 0;
  while (!(awready && wready) && n < handshake_limit) begin
    @(posedge clk);
    #2;
    n++;
  end
  if (!(awready && wready)) report_failure("write address and data were never accepted");
  @(posedge clk); // transfer edge
  #2;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  n = 0;
  while (!bvalid && n < handshake_limit) begin
    @(posedge clk);
    #2;
    n++;
  end
  if (!bvalid) report_failure("no write response arrived");
  @(posedge clk); // response held back for one cycle
  #2;
  if (!bvalid) report_failure("bvalid dropped before bready was raised");
  check_resp("bresp", b.resp, 2'b00);
  bready = 1'b1;
  @(posedge clk);
  #2;
  bready = 1'b0;
endtask

// hold = number of cycles rready stays low once rvalid is up
task automatic read_reg(input logic [axil_addr_w-1:0] addr, input int hold,
                        output logic [31:0] data);
  int      n;
  axil_r_t held;
  ar.addr = addr;
  arvalid = 1'b1;
  n = 0;
  while (!arready && n < handshake_limit) begin
    @(posedge clk);
    #2;
    n++;
  end
  if (!arready) report_failure("read address was never accepted");
  @(posedge clk);
  #2;
  arvalid = 1'b0;
  n = 0;
  while (!rvalid && n < handshake_limit) begin
    @(posedge clk);
    #2;
    n++;
  end
  if (!rvalid) report_failure("no read response arrived");
  held = r;
  repeat (hold) begin
    @(posedge clk);
    #2;
    if (!rvalid) report_failure("rvalid dropped before rready was raised");
    check_word("rdata", r.data, held.data);  // must not move while stalled
    check_resp("rresp", r.resp, held.resp);
  end
  rready = 1'b1;
  @(posedge clk);
  #2;
  rready = 1'b0;
  check_resp("rresp", held.resp, 2'b00);
  data = held.data;
endtask

task automatic wait_fill_done();
  logic [31:0] st;
  int          n;
  st = '0;
  n  = 0;
  while (!(st[1] && !st[0]) && n < poll_limit) begin // done set, busy clear
    read_reg(reg_status, 0, st);
    n++;
  end
  if (!(st[1] && !st[0])) report_failure("fill never reported done");
endtask

//--- verification/tb_gfx_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gfx_top;

  import gfx_pkg::*;

  localparam int fb_width        = 12;
  localparam int fb_height       = 4;
  localparam int handshake_limit = 50;
  localparam int poll_limit      = 200; // status reads per fill

  logic     clk = 1'b0;
  logic     reset;
  axil_aw_t aw;
  logic     awvalid;
  logic     awready;
  axil_w_t  w;
  logic     wvalid;
  logic     wready;
  axil_b_t  b;
  logic     bvalid;
  logic     bready;
  axil_aw_t ar;
  logic     arvalid;
  logic     arready;
  axil_r_t  r;
  logic     rvalid;
  logic     rready;

  gfx_color_t exp_q[$];  // expected pixels in readback order
  gfx_color_t got_q[$];
  int         checked  = 0;
  int         expected = 0;

  gfx_top #(.FB_WIDTH(fb_width), .FB_HEIGHT(fb_height)) uut (
    .clk, .reset,
    .aw, .awvalid, .awready,
    .w, .wvalid, .wready,
    .b, .bvalid, .bready,
    .ar, .arvalid, .arready,
    .r, .rvalid, .rready
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string why);
    $display("*** FAILED ***");
    $fatal(1, "%s", why);
  endtask

  `include "tb_gfx_tasks.svh"

  ////////////////////////////////////////
  // reference model and compare
  ////////////////////////////////////////
  function automatic gfx_color_t ref_pixel(input int x, input int y, input logic [1:0] pat,
                                           input gfx_color_t color);
    gfx_color_t c;
    if (pat == pat_checker) begin
      c = ((x % 2) != (y % 2)) ? 12'hfff : 12'h000;
    end else if (pat == pat_solid) begin
      c = color;
    end else if (x < fb_width / 3) begin // bars also cover the spare code
      c = 12'hf00;
    end else if (x < 2 * (fb_width / 3)) begin
      c = 12'h0f0;
    end else begin
      c = 12'h00f;
    end
    return c;
  endfunction

  always @(posedge clk) begin
    if (got_q.size() > 0 && exp_q.size() > 0) begin
      check_color("pix_data", got_q.pop_front(), exp_q.pop_front());
      checked++;
    end
  end

  function automatic logic [31:0] ctrl_word(input logic [1:0] pat, input gfx_color_t color,
                                            input logic go);
    return {16'h0, color, 1'b0, pat, go};
  endfunction

  task automatic run_fill(input logic [1:0] pat, input gfx_color_t color);
    logic [31:0] st;
    write_reg(reg_ctrl, ctrl_word(pat, color, 1'b1));
    read_reg(reg_status, 0, st);
    check_word("status", st, 32'h1); // busy while the sweep runs
    wait_fill_done();
  endtask

  task automatic readback_frame(input logic [1:0] pat, input gfx_color_t color,
                                input int max_hold);
    logic [31:0] word;
    int          hold;
    for (int y = 0; y < fb_height; y++) begin
      for (int x = 0; x < fb_width; x++) begin
        hold = (max_hold > 0) ? int'($urandom % 32'(max_hold + 1)) : 0;
        write_reg(reg_pix_addr, {16'h0, 8'(y), 8'(x)});
        read_reg(reg_pix_data, hold, word);
        check_word("pix_data upper bits", word & 32'hffff_f000, 32'h0);
        got_q.push_back(word[11:0]);
        exp_q.push_back(ref_pixel(x, y, pat, color));
        expected++;
      end
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    logic [31:0] word;
    gfx_color_t  solid;
    int          n;
    void'($urandom(32'hbd55568d));
    reset   = 1'b1;
    aw      = '0;
    awvalid = 1'b0;
    w       = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    ar      = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;

    read_reg(reg_status, 0, word);
    check_word("status", word, 32'h0);

    run_fill(pat_bars, 12'h000);
    readback_frame(pat_bars, 12'h000, 0);
    run_fill(pat_checker, 12'h000);
    readback_frame(pat_checker, 12'h000, 0);
    solid = gfx_pixel_bits'($urandom);
    run_fill(pat_solid, solid);
    readback_frame(pat_solid, solid, 0);

    // second start lands while the first fill is still busy
    write_reg(reg_ctrl, ctrl_word(pat_bars, 12'h5a3, 1'b1));
    write_reg(reg_ctrl, ctrl_word(pat_checker, 12'h3c7, 1'b1));
    wait_fill_done();
    readback_frame(pat_bars, 12'h5a3, 0);
    read_reg(reg_ctrl, 0, word);
    check_word("ctrl", word, ctrl_word(pat_checker, 12'h3c7, 1'b1) & 32'h0000_fffe);

    readback_frame(pat_bars, 12'h5a3, 6); // rready held off at random

    read_reg(4'h6, 0, word);
    check_word("unmapped", word, 32'h0);

    n = 0;
    while (got_q.size() > 0 && n < handshake_limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (got_q.size() > 0 || checked != expected) begin
      report_failure("not every pixel readback was compared");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verification
hw/gfx_pkg.sv
hw/gfx_test_pattern.sv
hw/gfx_fb_writer.sv
hw/gfx_framebuffer.sv
hw/gfx_ctrl_axil.sv
hw/gfx_top.sv
verification/tb_gfx_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wall -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_gfx_top
FILELIST  = sim.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
